//--- hw/csr_cfg.svh
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Register and CSR data width
`define CSR_XLEN 64

// CSR address field of the uop immediate
`define CSR_ADDR_W 12

// Reset values of the read-write CSRs
// mtvec comes up in direct mode at the boot trap vector
`define CSR_MTVEC_RESET 64'h0000_0000_0000_0100

// mscratch is cleared
`define CSR_MSCRATCH_RESET 64'h0000_0000_0000_0000

`endif

//--- hw/rv_instr_pkg.sv
`default_nettype none

`include "csr_cfg.svh"

package rv_instr_pkg;

    // Register file value and index
    typedef logic [`CSR_XLEN-1:0] t_rv_reg_data;

    // Also carries the zero-extended uimm of CSRRWI/CSRRSI/CSRRCI
    typedef logic [4:0] t_rv_reg_addr;

    // Micro-op encoding seen by the EX0 CSR unit
    typedef enum logic [3:0] {
        U_NOP   = 4'h0,
        U_CSRRW = 4'h1,
        U_CSRRS = 4'h2,
        U_CSRRC = 4'h3
    } t_uop;

    // Where the first source comes from
    typedef enum logic {
        OP_REG = 1'b0,
        OP_IMM = 1'b1
    } t_optype;

    typedef struct packed {
        t_optype      optype;
        t_rv_reg_addr opreg;
    } t_src_opnd;

    // Decoded micro-instruction
    // imm_11_0 holds the CSR address for CSR uops
    typedef struct packed {
        logic        valid;
        t_uop        uop;
        t_src_opnd   src1;
        logic [11:0] imm_11_0;
    } t_uinstr;

endpackage

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

`include "csr_cfg.svh"

package csr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] t_csr_addr;

    // Implemented CSR addresses
    localparam t_csr_addr CSRA_MTVEC    = 12'h305;
    localparam t_csr_addr CSRA_MSCRATCH = 12'h340;
    localparam t_csr_addr CSRA_CYCLE    = 12'hC00;
    localparam t_csr_addr CSRA_INSTRET  = 12'hC02;

    // Plain full-width payload
    // Used by mscratch and the two counters
    typedef struct packed {
        logic [`CSR_XLEN-1:0] data;
    } t_gen_csr;

    // Trap vector base and mode
    typedef struct packed {
        logic [`CSR_XLEN-3:0] base;
        logic [1:0]           mode;
    } t_csr_mtvec;

    // Only direct mode is supported, so mode is not writable
    localparam logic [`CSR_XLEN-1:0] MTVEC_WR_MASK = {{(`CSR_XLEN-2){1'b1}}, 2'b00};

    // All bits of a plain CSR are writable
    localparam logic [`CSR_XLEN-1:0] GEN_WR_MASK = '1;

endpackage

`default_nettype wire

//--- hw/gen_csr_ro.sv
`timescale 1ns/1ps
`default_nettype none

module gen_csr_ro #(
    parameter type                T        = csr_pkg::t_gen_csr,
    parameter csr_pkg::t_csr_addr CSR_ADDR = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // State is owned outside the slice
    input  T                           csr_state,

    input  logic                       valid_ex0,
    input  rv_instr_pkg::t_uinstr      uinstr_ex0,
    input  logic                       wr_en_ex0,
    output rv_instr_pkg::t_rv_reg_data rd_value_ex0,
    output logic                       hit_ex0,
    output logic                       wr_fault_ex0
);

    import rv_instr_pkg::*;
    import csr_pkg::*;

    t_csr_addr    csr_addr_ex0;
    t_rv_reg_data state_zext;

    assign csr_addr_ex0 = uinstr_ex0.imm_11_0;
    assign hit_ex0      = valid_ex0 && (csr_addr_ex0 == CSR_ADDR);

    // Any real write to this address is a fault
    assign wr_fault_ex0 = hit_ex0 && wr_en_ex0;

    // Zero-extend the payload to register width
    always_comb begin
        state_zext = '0;
        state_zext[$bits(T)-1:0] = csr_state;
    end

    assign rd_value_ex0 = hit_ex0 ? state_zext : '0;

    // Read data must stay off the shared OR bus unless addressed
    a_rd_zero_on_miss: assert property (
        @(posedge clk) disable iff (!rst_n)
        !hit_ex0 |-> (rd_value_ex0 == '0)
    );

endmodule

`default_nettype wire

//--- hw/gen_csr_rw.sv
`timescale 1ns/1ps
`default_nettype none

module gen_csr_rw #(
    parameter type                         T         = csr_pkg::t_gen_csr,
    parameter csr_pkg::t_csr_addr          CSR_ADDR  = '0,
    parameter T                            RESET_VAL = '0,
    parameter rv_instr_pkg::t_rv_reg_data  WR_MASK   = '1
) (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       valid_ex0,
    input  rv_instr_pkg::t_uinstr      uinstr_ex0,
    input  logic                       wr_en_ex0,
    input  rv_instr_pkg::t_rv_reg_data wr_value_ex0,
    output rv_instr_pkg::t_rv_reg_data rd_value_ex0,
    output logic                       hit_ex0,
    output T                           csr_state
);

    import rv_instr_pkg::*;
    import csr_pkg::*;

    T             csr_q;
    T             csr_d;
    t_csr_addr    csr_addr_ex0;
    t_rv_reg_data cur_ex0;
    t_rv_reg_data upd_ex0;
    t_rv_reg_data nxt_ex0;

    assign csr_addr_ex0 = uinstr_ex0.imm_11_0;
    assign hit_ex0      = valid_ex0 && (csr_addr_ex0 == CSR_ADDR);

    always_comb begin
        cur_ex0 = '0;
        cur_ex0[$bits(T)-1:0] = csr_q;
    end

    // Old value goes back as the uop result
    assign rd_value_ex0 = hit_ex0 ? cur_ex0 : '0;

    always_comb begin
        unique case (uinstr_ex0.uop)
            U_CSRRW: upd_ex0 = wr_value_ex0;
            U_CSRRS: upd_ex0 = cur_ex0 | wr_value_ex0;
            U_CSRRC: upd_ex0 = cur_ex0 & ~wr_value_ex0;
            default: upd_ex0 = cur_ex0;
        endcase
        // Bits outside the mask keep their current value
        nxt_ex0 = (upd_ex0 & WR_MASK) | (cur_ex0 & ~WR_MASK);
        csr_d   = nxt_ex0[$bits(T)-1:0];
    end

    // Commit at the end of EX0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            csr_q <= RESET_VAL;
        end else if (hit_ex0 && wr_en_ex0) begin
            csr_q <= csr_d;
        end
    end

    assign csr_state = csr_q;

    a_masked_bits_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        $stable(cur_ex0 & ~WR_MASK)
    );

endmodule

`default_nettype wire

//--- hw/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  logic              clk,
    input  logic              rst_n,

    // One pulse per retired micro-instruction
    input  logic              retire_valid,

    output csr_pkg::t_gen_csr cycle_cnt,
    output csr_pkg::t_gen_csr instret_cnt
);

    // Free-running clock count
    // Reads 0 in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt.data <= '0;
        end else begin
            cycle_cnt.data <= cycle_cnt.data + 1'b1;
        end
    end

    // Counts uops before the current one, so the
    // increment lands after the uop has been seen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instret_cnt.data <= '0;
        end else if (retire_valid) begin
            instret_cnt.data <= instret_cnt.data + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/icsr.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module icsr (
    input  logic                       clk,
    input  logic                       rst_n,

    input  rv_instr_pkg::t_uinstr      uinstr_ex0,
    input  rv_instr_pkg::t_rv_reg_data src1val_ex0,

    input  csr_pkg::t_gen_csr          cycle_cnt,
    input  csr_pkg::t_gen_csr          instret_cnt,

    output logic                       resvld_ex0,
    output rv_instr_pkg::t_rv_reg_data result_ex0,
    output logic                       csr_illegal_ex0
);

    import rv_instr_pkg::*;
    import csr_pkg::*;

    localparam int NUM_CSR = 4;

    // Slice positions on the read bus
    localparam int IDX_MTVEC    = 0;
    localparam int IDX_MSCRATCH = 1;
    localparam int IDX_CYCLE    = 2;
    localparam int IDX_INSTRET  = 3;

    localparam t_csr_mtvec MTVEC_RST    = `CSR_MTVEC_RESET;
    localparam t_gen_csr   MSCRATCH_RST = `CSR_MSCRATCH_RESET;

    logic               csr_uop_ex0;
    logic               valid_ex0;
    logic               wr_en_ex0;
    t_rv_reg_data       wr_value_ex0;
    t_rv_reg_data       rd_value_ex0 [NUM_CSR];
    logic [NUM_CSR-1:0] hit_ex0;
    logic [1:0]         wr_fault_ex0;
    t_rv_reg_data       rd_or_ex0;

    // Qualify
    assign csr_uop_ex0 = uinstr_ex0.uop inside {U_CSRRW, U_CSRRS, U_CSRRC};
    assign valid_ex0   = uinstr_ex0.valid && csr_uop_ex0;

    // uimm forms take the 5-bit field zero-extended
    assign wr_value_ex0 = (uinstr_ex0.src1.optype == OP_IMM) ?
                          t_rv_reg_data'(uinstr_ex0.src1.opreg) : src1val_ex0;

    // Set/clear with a zero operand is a pure read
    assign wr_en_ex0 = valid_ex0 &&
                       ((uinstr_ex0.uop == U_CSRRW) || (wr_value_ex0 != '0));

    gen_csr_rw #(
        .T         ( t_csr_mtvec   ),
        .CSR_ADDR  ( CSRA_MTVEC    ),
        .RESET_VAL ( MTVEC_RST     ),
        .WR_MASK   ( MTVEC_WR_MASK )
    ) u_csr_mtvec (
        .clk,
        .rst_n,
        .valid_ex0,
        .uinstr_ex0,
        .wr_en_ex0,
        .wr_value_ex0,
        .rd_value_ex0 ( rd_value_ex0[IDX_MTVEC] ),
        .hit_ex0      ( hit_ex0[IDX_MTVEC]      ),
        .csr_state    (                         )
    );

    gen_csr_rw #(
        .T         ( t_gen_csr     ),
        .CSR_ADDR  ( CSRA_MSCRATCH ),
        .RESET_VAL ( MSCRATCH_RST  ),
        .WR_MASK   ( GEN_WR_MASK   )
    ) u_csr_mscratch (
        .clk,
        .rst_n,
        .valid_ex0,
        .uinstr_ex0,
        .wr_en_ex0,
        .wr_value_ex0,
        .rd_value_ex0 ( rd_value_ex0[IDX_MSCRATCH] ),
        .hit_ex0      ( hit_ex0[IDX_MSCRATCH]      ),
        .csr_state    (                            )
    );

    gen_csr_ro #(.T(t_gen_csr), .CSR_ADDR(CSRA_CYCLE)) u_csr_cycle (
        .clk,
        .rst_n,
        .csr_state    ( cycle_cnt               ),
        .valid_ex0,
        .uinstr_ex0,
        .wr_en_ex0,
        .rd_value_ex0 ( rd_value_ex0[IDX_CYCLE] ),
        .hit_ex0      ( hit_ex0[IDX_CYCLE]      ),
        .wr_fault_ex0 ( wr_fault_ex0[0]         )
    );

    gen_csr_ro #(.T(t_gen_csr), .CSR_ADDR(CSRA_INSTRET)) u_csr_instret (
        .clk,
        .rst_n,
        .csr_state    ( instret_cnt               ),
        .valid_ex0,
        .uinstr_ex0,
        .wr_en_ex0,
        .rd_value_ex0 ( rd_value_ex0[IDX_INSTRET] ),
        .hit_ex0      ( hit_ex0[IDX_INSTRET]      ),
        .wr_fault_ex0 ( wr_fault_ex0[1]           )
    );

    // Slices drive zero when not addressed
    always_comb begin
        rd_or_ex0 = '0;
        for (int i = 0; i < NUM_CSR; i++) begin
            rd_or_ex0 = rd_or_ex0 | rd_value_ex0[i];
        end
    end

    assign csr_illegal_ex0 = valid_ex0 && ((hit_ex0 == '0) || (wr_fault_ex0 != '0));
    assign resvld_ex0      = valid_ex0;
    assign result_ex0      = csr_illegal_ex0 ? '0 : rd_or_ex0;

    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hit_ex0)
    );

endmodule

`default_nettype wire

//--- hw/csr_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_top (
    input  logic                       clk,
    input  logic                       rst_n,

    input  rv_instr_pkg::t_uinstr      uinstr_ex0,
    input  rv_instr_pkg::t_rv_reg_data src1val_ex0,

    output logic                       resvld_ex0,
    output rv_instr_pkg::t_rv_reg_data result_ex0,
    output logic                       csr_illegal_ex0
);

    import csr_pkg::*;

    t_gen_csr cycle_cnt;
    t_gen_csr instret_cnt;

    // No pipeline behind EX0, so every valid uop retires here
    csr_counters u_csr_counters (
        .clk,
        .rst_n,
        .retire_valid ( uinstr_ex0.valid ),
        .cycle_cnt,
        .instret_cnt
    );

    icsr u_icsr (
        .clk,
        .rst_n,
        .uinstr_ex0,
        .src1val_ex0,
        .cycle_cnt,
        .instret_cnt,
        .resvld_ex0,
        .result_ex0,
        .csr_illegal_ex0
    );

endmodule

`default_nettype wire

//--- dv/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "csr_cfg.svh"

module csr_unit_tb;

    import rv_instr_pkg::*;
    import csr_pkg::*;

    // One stimulus row with its behavior group first
    typedef struct packed {
        logic [2:0]   grp;
        logic         valid;
        t_uop         uop;
        t_optype      optype;
        t_rv_reg_addr opreg;
        t_csr_addr    addr;
        t_rv_reg_data src1;
    } t_row;

    logic         clk;
    logic         rst_n;
    t_uinstr      uinstr_ex0;
    t_rv_reg_data src1val_ex0;
    logic         resvld_ex0;
    t_rv_reg_data result_ex0;
    logic         csr_illegal_ex0;

    t_row         rows[$];
    integer       seed = 32'he86a;
    int           cycles;
    int           cycle_limit;
    int           n_pass;
    int           n_fail;

    // Reference state
    t_rv_reg_data m_mtvec;
    t_rv_reg_data m_mscratch;
    t_rv_reg_data m_cycle;
    t_rv_reg_data m_instret;

    csr_unit_top u_csr_unit_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic add_row(input int grp, input int valid, input t_uop uop,
                           input t_optype optype, input int opreg, input t_csr_addr addr,
                           input int rnd, input t_rv_reg_data src1);
        // Random operands are drawn once, when the table is built
        if (rnd != 0) begin
            src1 = {$random(seed), $random(seed)};
        end
        rows.push_back({3'(grp), valid != 0, uop, optype, 5'(opreg), addr, src1});
    endtask

    task automatic check_value(input string what, input t_rv_reg_data got,
                               input t_rv_reg_data exp, inout int errs);
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            errs++;
        end
    endtask

    task automatic build_table();
        // mscratch write then back-to-back accesses
        add_row(1, 1, U_CSRRW, OP_REG, 0, CSRA_MSCRATCH, 0, 64'h1234_5678_9abc_def0);
        add_row(1, 1, U_CSRRW, OP_REG, 0, CSRA_MSCRATCH, 1, '0);
        add_row(1, 1, U_CSRRW, OP_REG, 0, CSRA_MSCRATCH, 1, '0);
        add_row(1, 1, U_CSRRW, OP_REG, 0, CSRA_MSCRATCH, 0, 64'h0f0f_0f0f_0f0f_0f0f);
        // Set and clear in register and uimm forms
        add_row(2, 1, U_CSRRS, OP_REG, 0, CSRA_MSCRATCH, 0, 64'hf000_0000_0000_00f0);
        add_row(2, 1, U_CSRRC, OP_REG, 0, CSRA_MSCRATCH, 0, 64'h0f00_0000_0000_000f);
        add_row(2, 1, U_CSRRS, OP_IMM, 5'h15, CSRA_MSCRATCH, 0, '0);
        add_row(2, 1, U_CSRRC, OP_IMM, 5'h06, CSRA_MSCRATCH, 0, '0);
        // uimm of zero must ignore the register value
        add_row(2, 1, U_CSRRC, OP_IMM, 0, CSRA_MSCRATCH, 0, '1);
        add_row(2, 1, U_CSRRS, OP_REG, 0, CSRA_MSCRATCH, 0, '0);
        // mtvec mode stays direct
        add_row(3, 1, U_CSRRW, OP_REG, 0, CSRA_MTVEC, 0, '1);
        add_row(3, 1, U_CSRRC, OP_IMM, 5'h1f, CSRA_MTVEC, 0, '0);
        add_row(3, 1, U_CSRRS, OP_REG, 0, CSRA_MTVEC, 0, '0);
        // Counters with idle rows in between
        add_row(4, 1, U_CSRRS, OP_REG, 0, CSRA_CYCLE, 0, '0);
        add_row(4, 0, U_CSRRS, OP_REG, 0, CSRA_INSTRET, 0, '0);
        add_row(4, 0, U_CSRRS, OP_REG, 0, CSRA_INSTRET, 0, '0);
        add_row(4, 1, U_CSRRS, OP_REG, 0, CSRA_INSTRET, 0, '0);
        add_row(4, 1, U_CSRRS, OP_IMM, 0, CSRA_CYCLE, 0, '0);
        // Illegal accesses leave all state alone
        add_row(5, 1, U_CSRRS, OP_REG, 0, 12'h7c0, 0, '0);
        add_row(5, 1, U_CSRRW, OP_REG, 0, CSRA_CYCLE, 1, '0);
        add_row(5, 1, U_CSRRS, OP_IMM, 5'h04, CSRA_INSTRET, 0, '0);
        add_row(5, 1, U_CSRRW, OP_REG, 0, 12'h341, 1, '0);
        add_row(5, 1, U_CSRRC, OP_IMM, 0, CSRA_INSTRET, 0, '0);
        add_row(5, 1, U_CSRRS, OP_REG, 0, CSRA_MTVEC, 0, '0);
        // Idle and non-CSR uops
        add_row(6, 1, U_NOP, OP_REG, 0, CSRA_MSCRATCH, 1, '0);
        add_row(6, 0, U_CSRRW, OP_REG, 0, CSRA_MSCRATCH, 1, '0);
        add_row(6, 1, U_CSRRS, OP_REG, 0, CSRA_MSCRATCH, 0, '0);
        add_row(6, 1, U_CSRRS, OP_REG, 0, CSRA_INSTRET, 0, '0);
    endtask

    // Drives one row, checks it mid-cycle and steps the model at the edge
    task automatic run_row(input int idx, input t_row r);
        logic         csr_op;
        logic         wr_en;
        logic         ro;
        logic         mapped;
        logic         exp_ill;
        t_rv_reg_data wr_val;
        t_rv_reg_data old;
        t_rv_reg_data nxt;
        int           errs;
        errs   = 0;
        ro     = 1'b0;
        mapped = 1'b1;
        old    = '0;
        csr_op = r.valid && (r.uop inside {U_CSRRW, U_CSRRS, U_CSRRC});
        wr_val = (r.optype == OP_IMM) ? t_rv_reg_data'(r.opreg) : r.src1;
        wr_en  = csr_op && ((r.uop == U_CSRRW) || (wr_val != '0));
        case (r.addr)
            CSRA_MTVEC:    old = m_mtvec;
            CSRA_MSCRATCH: old = m_mscratch;
            CSRA_CYCLE: begin
                old = m_cycle;
                ro  = 1'b1;
            end
            CSRA_INSTRET: begin
                old = m_instret;
                ro  = 1'b1;
            end
            default:       mapped = 1'b0;
        endcase
        exp_ill = csr_op && (!mapped || (ro && wr_en));

        uinstr_ex0  = {r.valid, r.uop, r.optype, r.opreg, r.addr};
        src1val_ex0 = r.src1;
        @(negedge clk);
        check_value("resvld_ex0", resvld_ex0, csr_op, errs);
        check_value("csr_illegal_ex0", csr_illegal_ex0, exp_ill, errs);
        check_value("result_ex0", result_ex0, (csr_op && !exp_ill) ? old : '0, errs);

        if (wr_en && !exp_ill) begin
            case (r.uop)
                U_CSRRW: nxt = wr_val;
                U_CSRRS: nxt = old | wr_val;
                default: nxt = old & ~wr_val;
            endcase
            if (r.addr == CSRA_MTVEC) begin
                m_mtvec = {nxt[`CSR_XLEN-1:2], m_mtvec[1:0]};
            end else if (r.addr == CSRA_MSCRATCH) begin
                m_mscratch = nxt;
            end
        end
        m_cycle++;
        if (r.valid) begin
            m_instret++;
        end

        $display("row %0d (behavior %0d): %s", idx, r.grp, (errs == 0) ? "ok" : "FAILED");
        if (errs == 0) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n       = 1'b0;
        uinstr_ex0  = '0;
        src1val_ex0 = '0;
        m_mtvec     = `CSR_MTVEC_RESET;
        m_mscratch  = `CSR_MSCRATCH_RESET;
        m_cycle     = '0;
        m_instret   = '0;
        build_table();
        cycle_limit = rows.size() + 20;

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        foreach (rows[i]) begin
            run_row(i, rows[i]);
        end

        $display("Summary: %0d rows, %0d passed, %0d failed", rows.size(), n_pass, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hw
hw/rv_instr_pkg.sv
hw/csr_pkg.sv
hw/gen_csr_ro.sv
hw/gen_csr_rw.sv
hw/csr_counters.sv
hw/icsr.sv
hw/csr_unit_top.sv
dv/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_instr_pkg.sv
      - hw/csr_pkg.sv
      - hw/gen_csr_ro.sv
      - hw/gen_csr_rw.sv
      - hw/csr_counters.sv
      - hw/icsr.sv
      - hw/csr_unit_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/csr_unit_tb.sv
